//--- testbench/udp_tx_stimulus.txt
# columns: test name, payload length (decimal), first payload byte (hex),
# then bytes with tx_en high (decimal)
basic_40 40 00 94
pad_5 5 a0 72
one_byte 1 ff 72
pad_17 17 10 72
exact_18 18 20 72
len_19 19 30 73
len_32 32 40 86
len_33 33 50 87
max_64 64 60 118
len_47 47 70 101
len_2 2 80 72
len_63 63 90 117
len_24 24 c0 78
len_50 50 e0 104

//--- all.f
logic/udp_tx_pkg.sv
logic/stream_fifo.sv
logic/udp_header_builder.sv
logic/gmii_frame_tx.sv
logic/udp_tx_top.sv
testbench/tb_clock_gen.sv
testbench/udp_tx_properties.sv
testbench/udp_tx_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = udp_tx_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/udp_tx_tb.sv
`timescale 1ns/10ps

module udp_tx_tb;

    localparam udp_tx_pkg::mac_addr_t SRC_MAC      = 48'h02_11_22_33_44_55;
    localparam udp_tx_pkg::mac_addr_t DST_MAC      = 48'h02_aa_bb_cc_dd_ee;
    localparam udp_tx_pkg::ip_addr_t  SRC_IP       = 32'hc0a8_010a;
    localparam udp_tx_pkg::ip_addr_t  DST_IP       = 32'hc0a8_0114;
    localparam logic [15:0]           SRC_PORT     = 16'd5000;
    localparam logic [15:0]           DST_PORT_MIN = 16'd6000;
    localparam logic [15:0]           DST_PORT_MAX = 16'd6010;
    localparam logic [31:0]           SEED         = 32'hbe66_241f;
    localparam string                 STIM_FILE    = "testbench/udp_tx_stimulus.txt";

    logic                      clk;
    logic                      rst_n;
    udp_tx_pkg::send_req_t     req;
    logic                      req_valid;
    logic                      req_ready;
    udp_tx_pkg::payload_word_t payload;
    logic                      payload_valid;
    logic                      payload_ready;
    udp_tx_pkg::gmii_byte_t    gmii;
    logic                      frame_done;

    string       test_name[$];
    int          test_len[$];
    logic [7:0]  test_first[$];
    int          test_bytes[$];
    logic [7:0]  frame_data[$];  // captured bytes, all frames back to back
    int          frame_len[$];
    logic [7:0]  got[$];
    logic [7:0]  exp_frame[$];
    logic [31:0] exp_fcs;
    logic [15:0] exp_ident = 16'd0;
    logic [15:0] exp_port  = DST_PORT_MIN;
    string       cur_test;
    int          run_len = 0;
    int          done_pulses = 0;
    int          test_errors = 0;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(16)) tb_clock_gen_i (.clk(clk), .rst_n(rst_n));

    udp_tx_top #(
        .SRC_MAC (SRC_MAC), .DST_MAC (DST_MAC), .SRC_IP (SRC_IP), .DST_IP (DST_IP),
        .SRC_PORT (SRC_PORT), .DST_PORT_MIN (DST_PORT_MIN), .DST_PORT_MAX (DST_PORT_MAX),
        .PAYLOAD_DEPTH (16)
    ) udp_tx_top_i (
        .clk (clk), .rst_n (rst_n),
        .req (req), .req_valid (req_valid), .req_ready (req_ready),
        .payload (payload), .payload_valid (payload_valid), .payload_ready (payload_ready),
        .gmii (gmii), .frame_done (frame_done)
    );

    // **************************************************
    // reference model
    // **************************************************
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ data[b];  // bit 0 goes out first
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hedb8_8320;
            end
        end
        return c;
    endfunction

    function automatic logic [15:0] ip_checksum(input logic [15:0] total_len,
                                                input logic [15:0] ident);
        logic [31:0] sum;
        sum = 32'h4500 + total_len + ident + 32'h4000 + 32'h4011
            + SRC_IP[31:16] + SRC_IP[15:0] + DST_IP[31:16] + DST_IP[15:0];
        while (sum[31:16] != 16'd0) begin
            sum = sum[15:0] + sum[31:16];
        end
        return ~sum[15:0];
    endfunction

    task automatic push_be(input logic [63:0] value, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            exp_frame.push_back(value[8*i +: 8]);
        end
    endtask

    task automatic build_expected(input int len, input logic [7:0] first,
                                  input logic [15:0] total_len, input logic [15:0] udp_len,
                                  input logic [15:0] csum);
        logic [31:0] crc;
        int          padded;
        exp_frame.delete();
        padded = (len < 18) ? 18 : len;
        repeat (7) exp_frame.push_back(8'h55);
        exp_frame.push_back(8'hd5);
        push_be(DST_MAC, 6);
        push_be(SRC_MAC, 6);
        push_be(48'h0800, 2);
        push_be({16'h4500, total_len, exp_ident}, 6);
        push_be({16'h4000, 16'h4011, csum}, 6);
        push_be(SRC_IP, 4);
        push_be(DST_IP, 4);
        push_be({SRC_PORT, exp_port, udp_len, 16'h0000}, 8);  // zero udp checksum
        for (int k = 0; k < padded; k++) begin
            exp_frame.push_back((k < len) ? 8'(first + k) : 8'h00);
        end
        crc = 32'hffff_ffff;
        for (int i = 8; i < exp_frame.size(); i++) begin
            crc = crc_byte(crc, exp_frame[i]);
        end
        exp_fcs = ~crc;
        push_be(exp_fcs[7:0], 1);
        push_be(exp_fcs[15:8], 1);
        push_be(exp_fcs[23:16], 1);
        push_be(exp_fcs[31:24], 1);
    endtask

    // **************************************************
    // compare tasks
    // **************************************************
    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_field(input string what, input udp_tx_pkg::byte_count_t exp,
                               input udp_tx_pkg::byte_count_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    function automatic logic [15:0] get16(input int idx);
        return {got[idx], got[idx+1]};
    endfunction

    task automatic check_frame(input int i);
        int          n;
        logic [15:0] total_len;
        logic [15:0] udp_len;
        logic [15:0] csum;
        n = frame_len.pop_front();
        got.delete();
        repeat (n) got.push_back(frame_data.pop_front());
        cur_test    = test_name[i];
        test_errors = 0;
        exp_ident   = exp_ident + 16'd1;
        total_len   = 16'(test_len[i] + 28);
        udp_len     = 16'(test_len[i] + 8);
        csum        = ip_checksum(total_len, exp_ident);
        build_expected(test_len[i], test_first[i], total_len, udp_len, csum);
        check_field("byte count", 16'(test_bytes[i]), 16'(n));
        if (n == exp_frame.size()) begin
            check_field("eth type", 16'h0800, get16(20));
            check_field("total length", total_len, get16(24));
            check_field("ident", exp_ident, get16(26));
            check_field("checksum", csum, get16(32));
            check_field("dst port", exp_port, get16(44));
            check_field("udp length", udp_len, get16(46));
            check_word("fcs", exp_fcs, {got[n-1], got[n-2], got[n-3], got[n-4]});
            for (int k = 0; k < n; k++) begin
                if (got[k] !== exp_frame[k]) begin
                    check_byte($sformatf("byte %0d", k), exp_frame[k], got[k]);
                    break;  // one report per frame is enough
                end
            end
        end else begin
            $display("%s: %0d bytes captured, model frame has %0d, bytes not compared",
                     cur_test, n, exp_frame.size());
            test_errors++;
        end
        exp_port = (exp_port >= DST_PORT_MAX) ? DST_PORT_MIN : exp_port + 16'd1;
        if (test_errors == 0) begin
            passed++;
            $display("test %s: ok, %0d bytes", cur_test, n);
        end else begin
            failed++;
            $display("test %s: %0d errors", cur_test, test_errors);
        end
    endtask

    // **************************************************
    // stimulus, driven on falling edges
    // **************************************************
    task automatic send_request(input udp_tx_pkg::byte_count_t len);
        logic taken;
        repeat ($urandom_range(0, 3)) @(negedge clk);
        req.byte_count = len;
        req_valid      = 1'b1;
        taken          = 1'b0;
        while (!taken) begin
            #1;
            taken = req_ready;  // transfer on the next rising edge
            @(negedge clk);
        end
        req_valid = 1'b0;
    endtask

    task automatic send_payload(input int len, input logic [7:0] first);
        udp_tx_pkg::payload_word_t w;
        logic                      taken;
        for (int k = 0; k < (len + 3) / 4; k++) begin
            for (int j = 0; j < 4; j++) begin
                w[8*(3-j) +: 8] = (4*k + j < len) ? 8'(first + 4*k + j) : 8'h00;
            end
            repeat ($urandom_range(0, 3)) @(negedge clk);
            payload       = w;
            payload_valid = 1'b1;
            taken         = 1'b0;
            while (!taken) begin
                #1;
                taken = payload_ready;
                @(negedge clk);
            end
            payload_valid = 1'b0;
        end
    endtask

    // capture while tx_en is high, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (gmii.tx_en) begin
                frame_data.push_back(gmii.data);
                run_len++;
            end else if (run_len != 0) begin
                frame_len.push_back(run_len);
                run_len = 0;
            end
            if (frame_done) begin
                done_pulses++;
            end
        end
    end

    initial begin
        int    fd;
        string line;
        string name;
        int    len;
        int    first;
        int    nbytes;
        int    limit;
        req           = '0;
        req_valid     = 1'b0;
        payload       = '0;
        payload_valid = 1'b0;
        void'($urandom(SEED));
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%s %d %h %d", name, len, first, nbytes) == 4) begin
                test_name.push_back(name);
                test_len.push_back(len);
                test_first.push_back(8'(first));
                test_bytes.push_back(nbytes);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        limit = 200 * (test_name.size() + 1);
        foreach (test_bytes[i]) begin
            limit += test_bytes[i];
        end

        fork
            begin
                repeat (limit) @(posedge clk);
                $display("timeout: frames still missing after %0d cycles", limit);
                $display("*** TEST FAILED ***");
                $finish;
            end
        join_none

        @(posedge rst_n);
        @(negedge clk);
        fork
            begin
                for (int i = 0; i < test_name.size(); i++) begin
                    fork
                        send_request(udp_tx_pkg::byte_count_t'(test_len[i]));
                        send_payload(test_len[i], test_first[i]);
                    join
                end
            end
            begin
                for (int i = 0; i < test_name.size(); i++) begin
                    wait (frame_len.size() > 0);
                    check_frame(i);
                end
            end
        join

        repeat (20) @(negedge clk);
        if (done_pulses != test_name.size()) begin
            $display("frame_done pulsed %0d times for %0d requests",
                     done_pulses, test_name.size());
            errors++;
        end
        if (frame_len.size() != 0) begin
            $display("%0d frames captured beyond the requests", frame_len.size());
            errors++;
        end
        $display("tests: %0d passed, %0d failed, %0d other errors",
                 passed, failed, errors);
        if (failed == 0 && errors == 0 && test_name.size() > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- testbench/udp_tx_properties.sv
`timescale 1ns/10ps

module udp_tx_properties (
    input logic                    clk,
    input logic                    rst_n,
    input udp_tx_pkg::gmii_byte_t  gmii,
    input logic                    frame_done,
    input logic                    hdr_valid,
    input logic                    hdr_ready,
    input logic                    word_valid,
    input logic                    word_ready,
    input udp_tx_pkg::byte_count_t payload_len
);

    logic [15:0] run_len;    // cycles of tx_en so far
    logic [15:0] frame_len;  // 8 pre + 14 eth + 28 ip/udp + data + 4 fcs

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_len   <= 16'd0;
            frame_len <= 16'd0;
        end else if (gmii.tx_en) begin
            run_len <= run_len + 16'd1;
            if (run_len == 16'd0) begin
                frame_len <= 16'd54 + ((payload_len < 16'd18) ? 16'd18 : payload_len);
            end
        end else begin
            run_len <= 16'd0;
        end
    end

    frame_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gmii.tx_en) |-> (run_len == frame_len))
        else $error("tx_en burst length differs from header length");

    done_after_frame: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gmii.tx_en) |-> frame_done)
        else $error("frame_done missing after tx_en fell");

    done_only_at_end: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> ($past(gmii.tx_en) && !gmii.tx_en))
        else $error("frame_done without a preceding frame");

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |=> !frame_done)
        else $error("frame_done longer than one cycle");

    hdr_held: assert property (@(posedge clk) disable iff (!rst_n)
        (hdr_valid && !hdr_ready) |=> hdr_valid)
        else $error("hdr_valid withdrawn before acceptance");

    word_held: assert property (@(posedge clk) disable iff (!rst_n)
        (word_valid && !word_ready) |=> word_valid)
        else $error("word_valid withdrawn before acceptance");

endmodule

bind gmii_frame_tx udp_tx_properties udp_tx_properties_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .gmii        (gmii),
    .frame_done  (frame_done),
    .hdr_valid   (hdr_valid),
    .hdr_ready   (hdr_ready),
    .word_valid  (word_valid),
    .word_ready  (word_ready),
    .payload_len (hdr_r.payload_len)
);

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // release away from the active edge
    end

endmodule

//--- logic/udp_tx_top.sv
`timescale 1ns/10ps

module udp_tx_top #(
    parameter udp_tx_pkg::mac_addr_t SRC_MAC       = 48'h02_00_c0_a8_00_01,
    parameter udp_tx_pkg::mac_addr_t DST_MAC       = 48'h02_00_c0_a8_00_02,
    parameter udp_tx_pkg::ip_addr_t  SRC_IP        = 32'hc0a8_0001,
    parameter udp_tx_pkg::ip_addr_t  DST_IP        = 32'hc0a8_0002,
    parameter logic [15:0]           SRC_PORT      = 16'd1234,
    parameter logic [15:0]           DST_PORT_MIN  = 16'd1234,
    parameter logic [15:0]           DST_PORT_MAX  = 16'd1244,
    parameter int                    PAYLOAD_DEPTH = 16     // words, 64 byte payloads
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  udp_tx_pkg::send_req_t     req,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  udp_tx_pkg::payload_word_t payload,
    input  logic                      payload_valid,
    output logic                      payload_ready,
    output udp_tx_pkg::gmii_byte_t    gmii,
    output logic                      frame_done
);

    localparam int HDR_DEPTH = 2;  // next header computed while a frame goes out

    udp_tx_pkg::udp_header_t               built_hdr;
    logic                                  built_hdr_valid;
    logic                                  built_hdr_ready;
    udp_tx_pkg::udp_header_t               hdr;
    logic                                  hdr_valid;
    logic                                  hdr_ready;
    udp_tx_pkg::payload_word_t             word;
    logic                                  word_valid;
    logic                                  word_ready;
    logic [$clog2(PAYLOAD_DEPTH+1)-1:0]    payload_count;
    udp_tx_pkg::byte_count_t               word_count;

    assign word_count = udp_tx_pkg::byte_count_t'(payload_count);

    udp_header_builder #(
        .SRC_IP       (SRC_IP),
        .DST_IP       (DST_IP),
        .DST_PORT_MIN (DST_PORT_MIN),
        .DST_PORT_MAX (DST_PORT_MAX)
    ) udp_header_builder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .hdr       (built_hdr),
        .hdr_valid (built_hdr_valid),
        .hdr_ready (built_hdr_ready)
    );

    stream_fifo #(
        .ENTRY_T (udp_tx_pkg::udp_header_t),
        .DEPTH   (HDR_DEPTH)
    ) hdr_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (built_hdr),
        .in_valid  (built_hdr_valid),
        .in_ready  (built_hdr_ready),
        .out_data  (hdr),
        .out_valid (hdr_valid),
        .out_ready (hdr_ready),
        .count     ()
    );

    stream_fifo #(
        .ENTRY_T (udp_tx_pkg::payload_word_t),
        .DEPTH   (PAYLOAD_DEPTH)
    ) payload_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (payload),
        .in_valid  (payload_valid),
        .in_ready  (payload_ready),
        .out_data  (word),
        .out_valid (word_valid),
        .out_ready (word_ready),
        .count     (payload_count)
    );

    gmii_frame_tx #(
        .SRC_MAC  (SRC_MAC),
        .DST_MAC  (DST_MAC),
        .SRC_IP   (SRC_IP),
        .DST_IP   (DST_IP),
        .SRC_PORT (SRC_PORT)
    ) gmii_frame_tx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr        (hdr),
        .hdr_valid  (hdr_valid),
        .hdr_ready  (hdr_ready),
        .word       (word),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .word_count (word_count),
        .gmii       (gmii),
        .frame_done (frame_done)
    );

endmodule

//--- logic/gmii_frame_tx.sv
`timescale 1ns/10ps

module gmii_frame_tx #(
    parameter udp_tx_pkg::mac_addr_t SRC_MAC  = 48'h02_00_c0_a8_00_01,
    parameter udp_tx_pkg::mac_addr_t DST_MAC  = 48'h02_00_c0_a8_00_02,
    parameter udp_tx_pkg::ip_addr_t  SRC_IP   = 32'hc0a8_0001,
    parameter udp_tx_pkg::ip_addr_t  DST_IP   = 32'hc0a8_0002,
    parameter logic [15:0]           SRC_PORT = 16'd1234
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  udp_tx_pkg::udp_header_t   hdr,
    input  logic                      hdr_valid,
    output logic                      hdr_ready,
    input  udp_tx_pkg::payload_word_t word,
    input  logic                      word_valid,
    output logic                      word_ready,
    input  udp_tx_pkg::byte_count_t   word_count,
    output udp_tx_pkg::gmii_byte_t    gmii,
    output logic                      frame_done
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_PRE,
        PH_ETH,
        PH_IPH,
        PH_DATA,
        PH_FCS
    } phase_t;

    localparam logic [111:0] ETH_HDR = {DST_MAC, SRC_MAC, udp_tx_pkg::ETH_TYPE_IPV4};

    phase_t                  phase;
    logic [15:0]             cnt;         // byte index within the phase
    logic [15:0]             phase_last;  // index of final byte of the phase
    udp_tx_pkg::udp_header_t hdr_r;
    udp_tx_pkg::byte_count_t data_len;    // payload plus padding
    logic [31:0]             crc;
    logic [223:0]            ip_udp_hdr;
    logic [15:0]             need_words;
    logic                    start;
    logic                    real_byte;   // payload byte, not padding
    logic [7:0]              cur_byte;

    // wait for the whole payload so the data phase never stalls
    assign need_words = (hdr.payload_len + 16'd3) >> 2;
    assign start      = (phase == PH_IDLE) && hdr_valid && (word_count >= need_words);
    assign hdr_ready  = start;

    assign real_byte  = (phase == PH_DATA) && (cnt < hdr_r.payload_len);
    // pop after byte 3 of a word or after the last real byte
    assign word_ready = real_byte && word_valid &&
                        ((cnt[1:0] == 2'd3) || (cnt == hdr_r.payload_len - 16'd1));

    assign ip_udp_hdr = {
        udp_tx_pkg::IP_VER_IHL, udp_tx_pkg::IP_TOS, hdr_r.total_len,
        hdr_r.ident, udp_tx_pkg::IP_FLAGS_DF,
        udp_tx_pkg::IP_TTL, udp_tx_pkg::IP_PROTO_UDP, hdr_r.checksum,
        SRC_IP,
        DST_IP,
        SRC_PORT, hdr_r.dst_port,
        hdr_r.udp_len, 16'h0000         // no udp checksum
    };

    always_comb begin
        case (phase)
            PH_PRE:  phase_last = 16'd7;
            PH_ETH:  phase_last = 16'd13;
            PH_IPH:  phase_last = 16'd27;
            PH_DATA: phase_last = data_len - 16'd1;
            default: phase_last = 16'd3;
        endcase
    end

    // **************************************************
    // byte mux
    // **************************************************
    always_comb begin
        cur_byte = 8'h00;
        case (phase)
            PH_PRE: begin
                cur_byte = (cnt == 16'd7) ? udp_tx_pkg::SFD_BYTE : udp_tx_pkg::PREAMBLE_BYTE;
            end
            PH_ETH: begin
                cur_byte = ETH_HDR[8*(13 - cnt[3:0]) +: 8];
            end
            PH_IPH: begin
                cur_byte = ip_udp_hdr[8*(27 - cnt[4:0]) +: 8];
            end
            PH_DATA: begin
                if (real_byte) begin
                    cur_byte = word[8*(3 - cnt[1:0]) +: 8];  // big end first
                end
            end
            PH_FCS: begin
                // reflected crc, low byte first already in wire bit order
                cur_byte = ~crc[8*cnt[1:0] +: 8];
            end
            default: ;
        endcase
    end

    // **************************************************
    // phase FSM and registered gmii output
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= PH_IDLE;
            cnt        <= 16'd0;
            gmii       <= '0;
            frame_done <= 1'b0;
        end else begin
            gmii.tx_en <= (phase != PH_IDLE);
            gmii.data  <= cur_byte;
            frame_done <= gmii.tx_en && (phase == PH_IDLE);  // last fcs byte on the wire
            if (phase == PH_IDLE) begin
                cnt <= 16'd0;
                if (start) begin
                    phase <= PH_PRE;
                end
            end else if (cnt == phase_last) begin
                cnt <= 16'd0;
                case (phase)
                    PH_PRE:  phase <= PH_ETH;
                    PH_ETH:  phase <= PH_IPH;
                    PH_IPH:  phase <= PH_DATA;
                    PH_DATA: phase <= PH_FCS;
                    default: phase <= PH_IDLE;
                endcase
            end else begin
                cnt <= cnt + 16'd1;
            end
        end
    end

    // crc covers dst mac through padding
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= 32'hffff_ffff;
        end else if (phase == PH_IDLE) begin
            crc <= 32'hffff_ffff;
        end else if (phase == PH_ETH || phase == PH_IPH || phase == PH_DATA) begin
            crc <= udp_tx_pkg::crc32_step(crc, cur_byte);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            hdr_r    <= hdr;
            data_len <= (hdr.payload_len < udp_tx_pkg::MIN_PAYLOAD_BYTES)
                        ? udp_tx_pkg::MIN_PAYLOAD_BYTES : hdr.payload_len;
        end
    end

endmodule

//--- logic/udp_header_builder.sv
`timescale 1ns/10ps

module udp_header_builder #(
    parameter udp_tx_pkg::ip_addr_t SRC_IP       = 32'hc0a8_0001,
    parameter udp_tx_pkg::ip_addr_t DST_IP       = 32'hc0a8_0002,
    parameter logic [15:0]          DST_PORT_MIN = 16'd1234,
    parameter logic [15:0]          DST_PORT_MAX = 16'd1244
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  udp_tx_pkg::send_req_t   req,
    input  logic                    req_valid,
    output logic                    req_ready,
    output udp_tx_pkg::udp_header_t hdr,
    output logic                    hdr_valid,
    input  logic                    hdr_ready
);

    logic        busy;       // request taken, header not yet handed off
    logic [1:0]  step;       // checksum sequence position
    logic [15:0] ident_cnt;
    logic [15:0] next_port;
    logic [19:0] acc;        // ten 16 bit words fit in 20 bits
    logic        accept;
    logic        computing;

    assign req_ready = !busy;
    assign accept    = req_valid && !busy;
    assign computing = busy && !hdr_valid;

    // **************************************************
    // control: handshake, counters, sequence
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            step      <= 2'd0;
            hdr_valid <= 1'b0;
            ident_cnt <= 16'd0;
            next_port <= DST_PORT_MIN;
        end else begin
            if (accept) begin
                busy      <= 1'b1;
                step      <= 2'd0;
                ident_cnt <= ident_cnt + 16'd1;
                next_port <= (next_port >= DST_PORT_MAX) ? DST_PORT_MIN
                                                          : next_port + 16'd1;
            end else if (computing) begin
                step <= step + 2'd1;
                if (step == 2'd3) begin
                    hdr_valid <= 1'b1;  // checksum lands in the same edge
                end
            end else if (hdr_valid && hdr_ready) begin
                hdr_valid <= 1'b0;
                busy      <= 1'b0;
            end
        end
    end

    // **************************************************
    // header fields and checksum datapath
    // **************************************************
    always_ff @(posedge clk) begin
        if (accept) begin
            hdr.total_len   <= req.byte_count + udp_tx_pkg::IP_UDP_HDR_BYTES;
            hdr.ident       <= ident_cnt + 16'd1;
            hdr.checksum    <= 16'd0;
            hdr.dst_port    <= next_port;
            hdr.udp_len     <= req.byte_count + udp_tx_pkg::UDP_HDR_BYTES;
            hdr.payload_len <= req.byte_count;
        end else if (computing) begin
            case (step)
                2'd0: begin
                    // checksum word itself counts as zero
                    acc <= 20'({udp_tx_pkg::IP_VER_IHL, udp_tx_pkg::IP_TOS})
                         + 20'(hdr.total_len)
                         + 20'(hdr.ident)
                         + 20'(udp_tx_pkg::IP_FLAGS_DF)
                         + 20'({udp_tx_pkg::IP_TTL, udp_tx_pkg::IP_PROTO_UDP})
                         + 20'(SRC_IP[31:16]) + 20'(SRC_IP[15:0])
                         + 20'(DST_IP[31:16]) + 20'(DST_IP[15:0]);
                end
                2'd1, 2'd2: begin
                    acc <= 20'(acc[15:0]) + 20'(acc[19:16]);  // fold carries back in
                end
                default: begin
                    hdr.checksum <= ~acc[15:0];
                end
            endcase
        end
    end

endmodule

//--- logic/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo #(
    parameter type ENTRY_T = logic [31:0],
    parameter int  DEPTH   = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  ENTRY_T                       in_data,
    input  logic                         in_valid,
    output logic                         in_ready,
    output ENTRY_T                       out_data,
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    ENTRY_T        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          push;
    logic          pop;

    assign in_ready  = (count != DEPTH[$clog2(DEPTH+1)-1:0]);  // low only when full
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- logic/udp_tx_pkg.sv
package udp_tx_pkg;

    // **************************************************
    // protocol constants
    // **************************************************
    localparam logic [15:0] ETH_TYPE_IPV4     = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP      = 8'd17;
    localparam logic [15:0] IP_UDP_HDR_BYTES  = 16'd28;  // 20 ip + 8 udp
    localparam logic [15:0] UDP_HDR_BYTES     = 16'd8;
    localparam logic [15:0] MIN_PAYLOAD_BYTES = 16'd18;  // 46 min eth payload - 28
    localparam logic [7:0]  PREAMBLE_BYTE     = 8'h55;
    localparam logic [7:0]  SFD_BYTE          = 8'hd5;
    localparam logic [31:0] CRC_POLY          = 32'hedb8_8320;

    // fixed ipv4 header words
    localparam logic [7:0]  IP_VER_IHL  = 8'h45;   // v4, 5 x 32 bit
    localparam logic [7:0]  IP_TOS      = 8'h00;
    localparam logic [15:0] IP_FLAGS_DF = 16'h4000; // don't fragment, offset 0
    localparam logic [7:0]  IP_TTL      = 8'h40;

    // **************************************************
    // types
    // **************************************************
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] byte_count_t;
    typedef logic [31:0] payload_word_t;  // first wire byte in [31:24]

    typedef struct packed {
        byte_count_t byte_count;
    } send_req_t;

    // per-frame fields, everything else in the header is constant
    typedef struct packed {
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] checksum;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        byte_count_t payload_len;
    } udp_header_t;

    typedef struct packed {
        logic       tx_en;
        logic [7:0] data;
    } gmii_byte_t;

    // **************************************************
    // crc-32, reflected form, one byte per call
    // **************************************************
    function automatic logic [31:0] crc32_step(input logic [31:0] crc,
                                               input logic [7:0]  data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);  // lsb is first bit on wire
        end
        return c;
    endfunction

endpackage
